// File: all.f
+incdir+src
src/nr_timing_pkg.sv
src/framer_out_pkg.sv
src/iq_stream_if.sv
src/symbol_fifo.sv
src/sample_id_fifo.sv
src/grid_framer.sv
src/rg_framer_top.sv
dv/tb_rg_framer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the framer testbench with Verilator
# the result is taken from the log

cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir

verilator --binary --timing --assert --top-module tb_rg_framer -f all.f > "$log" 2>&1 \
    && ./obj_dir/Vtb_rg_framer >> "$log" 2>&1 \
    || echo "build or simulation returned an error" >> "$log"

cat "$log"
if grep -q "Simulation FAILED" "$log" || ! grep -q "Simulation PASSED" "$log"; then
    exit 1
fi
exit 0

// File: dv/tb_rg_framer.sv
//////////////////////////////
// self-checking testbench for the resource grid framer
// stimulus from a 32-bit Galois LFSR so every run is the same
// symbols of 8 to 40 IQ words, at most 3 ids written ahead
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "rg_defines.svh"

module tb_rg_framer
    import nr_timing_pkg::*;
    import framer_out_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_SYMS     = 20;
    localparam int MAX_LEN      = 40;
    localparam int ID_AHEAD_MAX = 3;
    localparam int IQ_W         = `RG_IQ_WIDTH;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    // every word behind a gap, plus framing and a late id, per symbol
    localparam int TIMEOUT_NS = (NUM_SYMS + 1) * (2 * MAX_LEN + 40) * CLK_PERIOD + 2000;

    logic                           clk = 1'b0;
    logic                           reset_ni;
    logic                           iq_valid;
    iq_word_t                       iq_data;
    logic                           iq_last;
    iq_user_t                       iq_user;
    logic                           id_valid;
    logic [`RG_SAMPLE_ID_WIDTH-1:0] id_data;
    logic                           tready;
    logic                           tvalid;
    iq_word_t                       tdata;
    logic                           tlast;
    logic                           overflow;
    logic                           irq;

    logic [31:0]    lfsr_state = 32'h9cfb;
    iq_word_t       iq_words [$];
    // expected output stream, one entry per word
    iq_word_t       exp_data [$];
    logic           exp_last [$];
    out_word_kind_t exp_kind [$];
    int             exp_sym  [$];
    int             ids_written = 0;
    int             int_count = 0;
    logic           ovf_allowed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rg_framer_top dut0 (
        .clk_i           (clk),
        .reset_ni        (reset_ni),
        .s_iq_valid_i    (iq_valid),
        .s_iq_data_i     (iq_data),
        .s_iq_last_i     (iq_last),
        .s_iq_user_i     (iq_user),
        .s_id_valid_i    (id_valid),
        .s_id_data_i     (id_data),
        .m_axis_tready_i (tready),
        .m_axis_tvalid_o (tvalid),
        .m_axis_tdata_o  (tdata),
        .m_axis_tlast_o  (tlast),
        .overflow_o      (overflow),
        .int_o           (irq)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    // one LFSR step per bit, newest bit at the lsb
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] bits;
        bits = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
            bits = {bits[62:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic void push_expected(input iq_word_t word, input logic last,
                                          input out_word_kind_t kind, input int idx);
        exp_data.push_back(word);
        exp_last.push_back(last);
        exp_kind.push_back(kind);
        exp_sym.push_back(idx);
    endfunction

    // reference model: blk_exp, timestamp low word first, then IQ words
    function automatic void expect_symbol(input int idx, input blk_exp_t blk_exp,
                                          input logic [`RG_SAMPLE_ID_WIDTH-1:0] id);
        push_expected(iq_word_t'(blk_exp), 1'b0, WK_BLK_EXP, idx);
        for (int w = 0; w < `RG_TS_WORDS; w++) begin
            push_expected(id[w*IQ_W +: IQ_W], 1'b0, WK_TIMESTAMP, idx);
        end
        for (int i = 0; i < iq_words.size(); i++) begin
            push_expected(iq_words[i], i == iq_words.size() - 1, WK_IQ, idx);
        end
    endfunction

    // keeps the id FIFO from filling up
    task automatic write_id(input logic [`RG_SAMPLE_ID_WIDTH-1:0] id);
        while (ids_written - int_count >= ID_AHEAD_MAX) begin
            @(negedge clk);
        end
        id_valid = 1'b1;
        id_data  = id;
        @(negedge clk);
        id_valid = 1'b0;
        ids_written++;
    endtask

    task automatic send_symbol(input int idx, input logic id_late);
        int                             len;
        int                             i;
        blk_exp_t                       blk_exp;
        logic [`RG_SAMPLE_ID_WIDTH-1:0] id;
        iq_user_t                       user;
        len     = 8 + int'(take_bits(6) % 64'd33);
        blk_exp = blk_exp_t'(take_bits(`RG_BLK_EXP_LEN));
        id      = take_bits(`RG_SAMPLE_ID_WIDTH);
        iq_words.delete();
        for (i = 0; i < len; i++) begin
            iq_words.push_back(iq_word_t'(take_bits(IQ_W)));
        end
        expect_symbol(idx, blk_exp, id);
        user.sfn      = sfn_t'(idx / 280);
        user.subframe = subframe_t'((idx / 14) % 20);
        user.symbol   = symbol_t'(idx % 14);
        user.blk_exp  = blk_exp;
        user.spare    = 1'b0;
        if (!id_late) begin
            write_id(id);
        end
        for (i = 0; i < len; i++) begin
            // roughly one word in four follows an idle strobe cycle
            if (take_bits(2) == 64'd0) begin
                iq_valid = 1'b0;
                @(negedge clk);
            end
            iq_valid = 1'b1;
            iq_data  = iq_words[i];
            iq_last  = (i == len - 1);
            iq_user  = user;
            @(negedge clk);
        end
        iq_valid = 1'b0;
        iq_last  = 1'b0;
        if (id_late) begin
            repeat (10) @(negedge clk);
            write_id(id);
        end
    endtask

    task automatic wait_for_symbols(input int n);
        while (int_count < n) begin
            @(negedge clk);
        end
    endtask

    task automatic check_word();
        iq_word_t       word;
        logic           last;
        out_word_kind_t kind;
        int             idx;
        assert (exp_data.size() != 0)
            else fail_run("output word valid while no word was expected");
        word = exp_data.pop_front();
        last = exp_last.pop_front();
        kind = exp_kind.pop_front();
        idx  = exp_sym.pop_front();
        // a timestamp word can only leave after its id was written
        if (kind == WK_TIMESTAMP) begin
            assert (ids_written > idx)
                else fail_run($sformatf("timestamp of symbol %0d sent before its id", idx));
        end
        assert (tdata == word)
            else fail_run($sformatf("ERROR at %0t: %s word of symbol %0d is %h, expected %h",
                                    $time, kind.name(), idx, tdata, word));
        assert (tlast == last)
            else fail_run($sformatf("ERROR at %0t: %s word of symbol %0d has tlast %b",
                                    $time, kind.name(), idx, tlast));
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (reset_ni) begin
            assert (ovf_allowed || !overflow)
                else fail_run($sformatf("ERROR at %0t: overflow_o set with tready high", $time));
            assert (irq == (tvalid && tlast))
                else fail_run($sformatf("ERROR at %0t: int_o is %b outside tlast", $time, irq));
            if (irq) begin
                int_count++;
            end
            if (tvalid) begin
                check_word();
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog timeout after %0d ns, the output stream stalled", TIMEOUT_NS);
        $display("Simulation FAILED");
        $fatal(1, "run stopped by the watchdog");
    end

    initial begin
        reset_ni    = 1'b0;
        iq_valid    = 1'b0;
        iq_data     = '0;
        iq_last     = 1'b0;
        iq_user     = '0;
        id_valid    = 1'b0;
        id_data     = '0;
        tready      = 1'b1;
        ovf_allowed = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_ni = 1'b1;

        // every fifth symbol gets its id only after its IQ words
        for (int s = 0; s < NUM_SYMS; s++) begin
            send_symbol(s, (s % 5) == 4);
        end
        wait_for_symbols(NUM_SYMS);

        // one more symbol with tready dropped for a single valid word
        send_symbol(NUM_SYMS, 1'b0);
        while (!tvalid) begin
            @(negedge clk);
        end
        ovf_allowed = 1'b1;
        tready      = 1'b0;
        @(negedge clk);
        tready = 1'b1;
        wait_for_symbols(NUM_SYMS + 1);
        repeat (10) begin
            @(negedge clk);
            assert (overflow)
                else fail_run($sformatf("ERROR at %0t: overflow_o cleared without a reset",
                                        $time));
        end

        reset_ni = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_ni = 1'b1;
        @(negedge clk);
        assert (!overflow)
            else fail_run($sformatf("ERROR at %0t: overflow_o still set after reset", $time));
        ovf_allowed = 1'b0;

        assert (int_count == NUM_SYMS + 1)
            else fail_run($sformatf("ERROR at %0t: %0d interrupt pulses for %0d symbols",
                                    $time, int_count, NUM_SYMS + 1));
        assert (exp_data.size() == 0)
            else fail_run($sformatf("%0d expected words never left the DUT", exp_data.size()));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/rg_framer_top.sv
//////////////////////////////
// resource grid framer, receive side after the FFT demodulator
// IQ input has no ready, one symbol must fit in the symbol FIFO
// sfn, subframe and symbol fields of tuser are not used here
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "rg_defines.svh"

module rg_framer_top
    import nr_timing_pkg::*;
(
    input  wire                            clk_i,
    input  wire                            reset_ni,

    // FFT demodulator side
    input  wire                            s_iq_valid_i,
    input  wire [`RG_IQ_WIDTH-1:0]         s_iq_data_i,
    input  wire                            s_iq_last_i,
    input  wire iq_user_t                  s_iq_user_i,

    // sample id write strobe
    input  wire                            s_id_valid_i,
    input  wire [`RG_SAMPLE_ID_WIDTH-1:0]  s_id_data_i,

    // DMA side
    input  wire                            m_axis_tready_i,
    output logic                           m_axis_tvalid_o,
    output logic [`RG_IQ_WIDTH-1:0]        m_axis_tdata_o,
    output logic                           m_axis_tlast_o,

    output logic                           overflow_o,
    output logic                           int_o
);

    blk_exp_t                       s_iq_blk_exp;
    logic                           id_valid;
    logic [`RG_SAMPLE_ID_WIDTH-1:0] id_data;
    logic                           id_ready;

    iq_stream_if sym_if ();

    assign s_iq_blk_exp = s_iq_user_i.blk_exp;

    symbol_fifo symbol_fifo0 (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .wr_valid_i   (s_iq_valid_i),
        .wr_data_i    (s_iq_data_i),
        .wr_last_i    (s_iq_last_i),
        .wr_blk_exp_i (s_iq_blk_exp),
        .rd           (sym_if.producer)
    );

    sample_id_fifo sample_id_fifo0 (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_valid_i (s_id_valid_i),
        .wr_id_i    (s_id_data_i),
        .rd_valid_o (id_valid),
        .rd_id_o    (id_data),
        .rd_ready_i (id_ready)
    );

    grid_framer grid_framer0 (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .sym             (sym_if.consumer),
        .id_valid_i      (id_valid),
        .id_data_i       (id_data),
        .id_ready_o      (id_ready),
        .m_axis_tready_i (m_axis_tready_i),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tlast_o  (m_axis_tlast_o),
        .overflow_o      (overflow_o),
        .int_o           (int_o)
    );

endmodule

`default_nettype wire

// File: src/grid_framer.sv
//////////////////////////////
// frames each symbol as blk_exp, timestamp words (low first), IQ words
// output never stalls, back-pressure only sets the sticky overflow flag
// waits with valid low until the symbol's id is present
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "rg_defines.svh"

module grid_framer
    import framer_out_pkg::*;
(
    input  wire                            clk_i,
    input  wire                            reset_ni,

    // buffered symbol from the FIFO
    iq_stream_if.consumer                  sym,

    // timestamp link
    input  wire                            id_valid_i,
    input  wire [`RG_SAMPLE_ID_WIDTH-1:0]  id_data_i,
    output logic                           id_ready_o,

    // stream towards the DMA
    input  wire                            m_axis_tready_i,
    output logic                           m_axis_tvalid_o,
    output iq_word_t                       m_axis_tdata_o,
    output logic                           m_axis_tlast_o,

    output logic                           overflow_o,
    output logic                           int_o
);

    localparam int TS_CNT_W = $clog2(`RG_TS_WORDS);
    // counter value while the final timestamp word is sent
    localparam logic [TS_CNT_W-1:0] TS_REST_LAST = TS_CNT_W'(`RG_TS_WORDS - 2);

    framer_state_t                  state_q;
    logic [TS_CNT_W-1:0]            ts_cnt_q;
    logic [`RG_SAMPLE_ID_WIDTH-1:0] ts_shift_q;
    out_word_kind_t                 out_kind_q;

    // id is taken in the cycle it is captured
    assign id_ready_o = (state_q == FR_TS_FIRST);
    assign sym.ready  = (state_q == FR_IQ);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q         <= FR_IDLE;
            ts_cnt_q        <= '0;
            m_axis_tvalid_o <= 1'b0;
            m_axis_tlast_o  <= 1'b0;
            int_o           <= 1'b0;
        end else begin
            m_axis_tlast_o <= 1'b0;
            int_o          <= 1'b0;
            case (state_q)
                FR_IDLE: begin
                    // head of the FIFO is the first word of the next symbol
                    m_axis_tvalid_o <= sym.valid;
                    if (sym.valid) begin
                        state_q <= FR_TS_FIRST;
                    end
                end
                FR_TS_FIRST: begin
                    m_axis_tvalid_o <= id_valid_i;
                    if (id_valid_i) begin
                        ts_cnt_q <= '0;
                        state_q  <= FR_TS_REST;
                    end
                end
                FR_TS_REST: begin
                    m_axis_tvalid_o <= 1'b1;
                    ts_cnt_q        <= ts_cnt_q + 1'b1;
                    if (ts_cnt_q == TS_REST_LAST) begin
                        state_q <= FR_IQ;
                    end
                end
                FR_IQ: begin
                    // input gaps pass through as idle output cycles
                    m_axis_tvalid_o <= sym.valid;
                    if (sym.valid && sym.last) begin
                        m_axis_tlast_o <= 1'b1;
                        int_o          <= 1'b1;
                        state_q        <= FR_IDLE;
                    end
                end
                default: state_q <= FR_IDLE;
            endcase
        end
    end

    // output payload, qualified by m_axis_tvalid_o
    always_ff @(posedge clk_i) begin
        case (state_q)
            FR_IDLE: begin
                m_axis_tdata_o <= {{(`RG_IQ_WIDTH - `RG_BLK_EXP_LEN){1'b0}}, sym.blk_exp};
                out_kind_q     <= WK_BLK_EXP;
            end
            FR_TS_FIRST: begin
                m_axis_tdata_o <= id_data_i[`RG_IQ_WIDTH-1:0];
                ts_shift_q     <= id_data_i >> `RG_IQ_WIDTH;
                out_kind_q     <= WK_TIMESTAMP;
            end
            FR_TS_REST: begin
                m_axis_tdata_o <= ts_shift_q[`RG_IQ_WIDTH-1:0];
                ts_shift_q     <= ts_shift_q >> `RG_IQ_WIDTH;
                out_kind_q     <= WK_TIMESTAMP;
            end
            default: begin
                m_axis_tdata_o <= sym.data;
                out_kind_q     <= WK_IQ;
            end
        endcase
    end

    // sticky until reset
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            overflow_o <= 1'b0;
        end else if (m_axis_tvalid_o && !m_axis_tready_i) begin
            overflow_o <= 1'b1;
        end
    end

    a_tlast_on_iq_word: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        m_axis_tlast_o |-> (m_axis_tvalid_o && out_kind_q == WK_IQ)
    ) else $error("grid_framer: tlast without a valid IQ word");

    a_int_with_tlast: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        int_o |-> m_axis_tlast_o
    ) else $error("grid_framer: interrupt outside the tlast cycle");

endmodule

`default_nettype wire

// File: src/sample_id_fifo.sv
//////////////////////////////
// shallow timestamp buffer, first-word-fall-through
// a write while full is dropped
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "rg_defines.svh"

module sample_id_fifo (
    input  wire                            clk_i,
    input  wire                            reset_ni,
    input  wire                            wr_valid_i,
    input  wire [`RG_SAMPLE_ID_WIDTH-1:0]  wr_id_i,
    output logic                           rd_valid_o,
    output logic [`RG_SAMPLE_ID_WIDTH-1:0] rd_id_o,
    input  wire                            rd_ready_i
);

    localparam int DEPTH = `RG_SAMPLE_ID_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    logic [`RG_SAMPLE_ID_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]               wr_ptr_q;
    logic [PTR_W-1:0]               rd_ptr_q;
    logic [PTR_W:0]                 count_q;
    logic                           push;
    logic                           pop;

    assign push = wr_valid_i && (count_q != FULL_COUNT);
    assign pop  = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_id_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(push);
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop);
            count_q  <= count_q + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

    assign rd_valid_o = (count_q != '0);
    assign rd_id_o    = mem[rd_ptr_q];

    // ids may run ahead of symbols, but never by more than the depth
    a_no_write_when_full: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        wr_valid_i |-> (count_q != FULL_COUNT)
    ) else $error("sample_id_fifo: write while full, timestamp lost");

endmodule

`default_nettype wire

// File: src/symbol_fifo.sv
//////////////////////////////
// symbol buffer, first-word-fall-through read side
// a write while full is dropped, upstream has no ready
// depth must be a power of two
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "rg_defines.svh"

module symbol_fifo
    import nr_timing_pkg::*;
    import framer_out_pkg::*;
(
    input  wire                 clk_i,
    input  wire                 reset_ni,

    // write side from the FFT demodulator
    input  wire                 wr_valid_i,
    input  wire iq_word_t       wr_data_i,
    input  wire                 wr_last_i,
    input  wire blk_exp_t       wr_blk_exp_i,

    // read side towards the framer
    iq_stream_if.producer       rd
);

    localparam int DEPTH = `RG_SYMBOL_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    iq_word_t         mem_data    [DEPTH];
    logic             mem_last    [DEPTH];
    blk_exp_t         mem_blk_exp [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count_q == FULL_COUNT);
    assign push = wr_valid_i && !full;
    assign pop  = rd.valid && rd.ready;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_data[wr_ptr_q]    <= wr_data_i;
            mem_last[wr_ptr_q]    <= wr_last_i;
            mem_blk_exp[wr_ptr_q] <= wr_blk_exp_i;
        end
    end

    // pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // head word is visible as soon as the count is nonzero
    assign rd.valid   = (count_q != '0);
    assign rd.data    = mem_data[rd_ptr_q];
    assign rd.last    = mem_last[rd_ptr_q];
    assign rd.blk_exp = mem_blk_exp[rd_ptr_q];

    // the demodulator must never get a full symbol ahead of the framer
    a_no_write_when_full: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        wr_valid_i |-> !full
    ) else $error("symbol_fifo: write while full, IQ word lost");

endmodule

`default_nettype wire

// File: src/iq_stream_if.sv
//////////////////////////////
// symbol stream between the symbol FIFO and the framer
// a word moves when valid and ready are both high
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "rg_defines.svh"

interface iq_stream_if;

    logic [`RG_IQ_WIDTH-1:0]    data;
    logic                       valid;
    // marks the final IQ word of a symbol
    logic                       last;
    // block exponent of the symbol this word belongs to
    logic [`RG_BLK_EXP_LEN-1:0] blk_exp;
    logic                       ready;

    modport producer (
        output data, valid, last, blk_exp,
        input  ready
    );

    modport consumer (
        input  data, valid, last, blk_exp,
        output ready
    );

endinterface

`default_nettype wire

// File: src/framer_out_pkg.sv
//////////////////////////////
// types of the framer and of its output stream
//////////////////////////////
`default_nettype none
`include "rg_defines.svh"

package framer_out_pkg;

    // one word on the output stream, also one IQ word
    typedef logic [`RG_IQ_WIDTH-1:0] iq_word_t;

    typedef enum logic [1:0] {
        FR_IDLE,
        FR_TS_FIRST,
        FR_TS_REST,
        FR_IQ
    } framer_state_t;

    // what a given output word carries
    typedef enum logic [1:0] {
        WK_BLK_EXP,
        WK_TIMESTAMP,
        WK_IQ
    } out_word_kind_t;

endpackage

`default_nettype wire

// File: src/nr_timing_pkg.sv
//////////////////////////////
// NR frame numbering types and the packed tuser layout
// ranges are not checked in hardware
//////////////////////////////
`default_nettype none
`include "rg_defines.svh"

package nr_timing_pkg;

    // system frame number, 0 to 1023
    typedef logic [9:0] sfn_t;

    // subframe in the frame, 0 to 19
    typedef logic [4:0] subframe_t;

    // OFDM symbol in the subframe, 0 to 13
    typedef logic [3:0] symbol_t;

    typedef logic [`RG_BLK_EXP_LEN-1:0] blk_exp_t;

    // tuser as sent by the FFT demodulator, msb first
    // blk_exp lands in bits 8:1, spare is bit 0
    typedef struct packed {
        sfn_t      sfn;
        subframe_t subframe;
        symbol_t   symbol;
        blk_exp_t  blk_exp;
        logic      spare;
    } iq_user_t;

endpackage

`default_nettype wire

// File: src/rg_defines.svh
//////////////////////////////
// widths and depths shared by the framer RTL and the testbench
// the sample id width must be a multiple of the IQ width
// both FIFO depths must be powers of two
//////////////////////////////
`ifndef RG_DEFINES_SVH
`define RG_DEFINES_SVH

// one IQ word, also the width of every output word
`define RG_IQ_WIDTH 16

// block exponent from the FFT demodulator
`define RG_BLK_EXP_LEN 8

// timestamp width
`define RG_SAMPLE_ID_WIDTH 64

// one full symbol, up to 1024 subcarriers
`define RG_SYMBOL_FIFO_DEPTH 1024
`define RG_SAMPLE_ID_FIFO_DEPTH 4

// output words needed to carry one timestamp
`define RG_TS_WORDS (`RG_SAMPLE_ID_WIDTH / `RG_IQ_WIDTH)

`endif
